// ==== build.f ====
+incdir+common
common/memPkg.sv
logic/respSlot.sv
logic/byteRam.sv
memctrl/memRequestDecode.sv
memctrl/memByteSequencer.sv
memctrl/memResultRouter.sv
logic/memSubsystem.sv
verif/memSubsystem_assertions.sv
verif/memSubsystemTb.sv

// ==== verif/memSubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module memSubsystemTb;
    import memPkg::*;

    localparam int RANDOM_OPS   = 200;
    localparam int DIRECTED_OPS = 23;
    localparam int WINDOW       = 128;
    localparam int PRELOAD_OPS  = WINDOW / 4;
    localparam int STALL_CYCLES = 30;
    localparam int CYCLE_LIMIT  =
        (RANDOM_OPS + DIRECTED_OPS + PRELOAD_OPS) * 12 + STALL_CYCLES + 200;

    logic     clk;
    logic     rst;
    logic     hold;
    logic     fetchValid;
    fetchReqT fetchReq;
    logic     fetchReady;
    logic     dataValid;
    dataReqT  dataReq;
    logic     dataReady;
    logic     instValid;
    instT     inst;
    logic     instReady;
    logic     dataRespValid;
    dataRespT dataResp;
    logic     dataRespReady;

    logic [7:0]  refMem [`MEM_DEPTH];
    instT        instExpQ[$];
    dataRespT    dataExpQ[$];
    dataRespT    fetchResp;
    logic [31:0] opWord [RANDOM_OPS];
    logic [31:0] opData [RANDOM_OPS];
    logic [31:0] readyBits;
    logic        randomReady;
    integer      seed = 46;
    int          checkCount;
    int          errCount;
    int          testErrStart;
    int          cycleCount;
    time         dataAcceptTime;
    time         fetchAcceptTime;
    time         lastDataRespTime;
    time         lastInstRespTime;

    memSubsystem dut_i (
        .clk             (clk),
        .rst             (rst),
        .i_hold          (hold),
        .i_fetchValid    (fetchValid),
        .i_fetchReq      (fetchReq),
        .o_fetchReady    (fetchReady),
        .i_dataValid     (dataValid),
        .i_dataReq       (dataReq),
        .o_dataReady     (dataReady),
        .o_instValid     (instValid),
        .o_inst          (inst),
        .i_instReady     (instReady),
        .o_dataRespValid (dataRespValid),
        .o_dataResp      (dataResp),
        .i_dataRespReady (dataRespReady)
    );

    bind memSubsystem memSubsystem_assertions protocolChecks (
        .clk             (clk),
        .rst             (rst),
        .i_fetchReady    (o_fetchReady),
        .i_dataReady     (o_dataReady),
        .i_instValid     (o_instValid),
        .i_inst          (o_inst),
        .i_instReady     (i_instReady),
        .i_dataRespValid (o_dataRespValid),
        .i_dataResp      (o_dataResp),
        .i_dataRespReady (i_dataRespReady),
        .i_ramWe         (ramWe)
    );

    // little-endian gather from the model, zero above the length
    function automatic dataRespT expectedResp(input opKindT kind,
            input logic [`MEM_ADDR_W-1:0] addr, input logic [`LEN_W-1:0] len);
        dataRespT resp;
        int i;
        resp = '0;
        if (kind == opStore) begin
            resp.storeAck = 1'b1;
        end else begin
            for (i = 0; i < len; i++) begin
                resp.rdData[8*i +: 8] = refMem[addr + i[`MEM_ADDR_W-1:0]];
            end
        end
        return resp;
    endfunction

    function automatic logic [7:0] fillByte(input logic [`MEM_ADDR_W-1:0] addr);
        return addr[7:0] ^ {addr[11:8], addr[11:8]} ^ 8'h5C;
    endfunction

    task automatic recordStore(input dataReqT req);
        int i;
        for (i = 0; i < req.len; i++) begin
            refMem[req.addr + i[`MEM_ADDR_W-1:0]] = req.wrData[8*i +: 8];
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the accept
    task automatic sendData(input logic store, input logic [`MEM_ADDR_W-1:0] addr,
            input logic [`LEN_W-1:0] len, input logic [31:0] wrData);
        dataReq.addr   = addr;
        dataReq.store  = store;
        dataReq.len    = len;
        dataReq.wrData = wrData;
        dataValid      = 1'b1;
        @(posedge clk);
        while (!dataReady) begin
            @(posedge clk);
        end
        @(negedge clk);
        dataValid = 1'b0;
    endtask

    task automatic sendFetch(input logic [`MEM_ADDR_W-1:0] addr);
        fetchReq.addr = addr;
        fetchValid    = 1'b1;
        @(posedge clk);
        while (!fetchReady) begin
            @(posedge clk);
        end
        @(negedge clk);
        fetchValid = 1'b0;
    endtask

    task automatic drain();
        while (instExpQ.size() != 0 || dataExpQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic endTest(input string name);
        $display("test %s: %0d mismatches", name, errCount - testErrStart);
        testErrStart = errCount;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // mirror accepted requests into the model
    always @(posedge clk) begin
        if (!rst && dataValid && dataReady) begin
            dataAcceptTime = $time;
            dataExpQ.push_back(expectedResp(dataReq.store ? opStore : opLoad,
                dataReq.addr, dataReq.len));
            if (dataReq.store) begin
                recordStore(dataReq);
            end
        end
        if (!rst && fetchValid && fetchReady) begin
            fetchAcceptTime = $time;
            fetchResp = expectedResp(opFetch, fetchReq.addr, `FETCH_BYTES);
            instExpQ.push_back(fetchResp.rdData);
        end
    end

    always @(posedge clk) begin
        if (!rst && instValid && instReady) begin
            lastInstRespTime = $time;
            if (instExpQ.size() == 0) begin
                errCount++;
                $display("ERROR at %0t: instruction response with no fetch pending", $time);
            end else begin
                checkValue("o_inst", instExpQ.pop_front(), inst);
            end
        end
        if (!rst && dataRespValid && dataRespReady) begin
            lastDataRespTime = $time;
            if (dataExpQ.size() == 0) begin
                errCount++;
                $display("ERROR at %0t: data response with no request pending", $time);
            end else begin
                checkValue("o_dataResp.rdData", dataExpQ[0].rdData, dataResp.rdData);
                checkValue("o_dataResp.storeAck", dataExpQ[0].storeAck, dataResp.storeAck);
                void'(dataExpQ.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (randomReady) begin
            readyBits     = $random(seed);
            instReady     = readyBits[0];
            dataRespReady = readyBits[1];
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("ERROR: run timed out waiting for a response after %0d cycles", cycleCount);
        $display("Finished with errors");
        $finish;
    end

    initial begin : mainFlow
        int                     a;
        int                     n;
        logic [31:0]            w;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]      len;
        instT                   heldInst;
        rst           = 1'b1;
        hold          = 1'b0;
        fetchValid    = 1'b0;
        fetchReq      = '0;
        dataValid     = 1'b0;
        dataReq       = '0;
        instReady     = 1'b1;
        dataRespReady = 1'b1;
        randomReady   = 1'b0;
        checkCount    = 0;
        errCount      = 0;
        testErrStart  = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        // RAM powers up unknown, so fill the working window first
        for (a = 0; a < WINDOW; a += 4) begin
            addr = a[`MEM_ADDR_W-1:0];
            sendData(1'b1, addr, `LEN_WORD,
                {fillByte(addr + 3), fillByte(addr + 2), fillByte(addr + 1), fillByte(addr)});
        end
        drain();
        endTest("preload");

        sendData(1'b1, 12'h040, `LEN_BYTE, 32'h000000A5);
        sendData(1'b1, 12'h050, `LEN_HALF, 32'h0000BEEF);
        sendData(1'b1, 12'h060, `LEN_WORD, 32'h12345678);
        for (a = 0; a < 3; a++) begin
            addr = 12'h040 + a[`MEM_ADDR_W-1:0] * 12'h010;
            sendData(1'b0, addr, `LEN_BYTE, 32'h0);
            sendData(1'b0, addr, `LEN_HALF, 32'h0);
            sendData(1'b0, addr, `LEN_WORD, 32'h0);
        end
        drain();
        endTest("byte lengths");

        sendData(1'b1, 12'h070, `LEN_WORD, 32'hCAFEF00D);
        sendFetch(12'h070);
        sendFetch(12'h000);
        drain();
        endTest("fetch");

        fork
            sendData(1'b0, 12'h060, `LEN_WORD, 32'h0);
            sendFetch(12'h040);
        join
        drain();
        checkValue("o_dataReady before o_fetchReady", 1, dataAcceptTime < fetchAcceptTime);
        checkValue("data response first", 1, lastDataRespTime < lastInstRespTime);
        endTest("arbitration");

        instReady = 1'b0;
        sendFetch(12'h010);
        while (!instValid) begin
            @(negedge clk);
        end
        heldInst = instExpQ[0];
        sendData(1'b0, 12'h020, `LEN_WORD, 32'h0);
        while (dataExpQ.size() != 0) begin
            @(negedge clk);
        end
        fork
            sendFetch(12'h030);
            begin
                repeat (20) begin
                    @(posedge clk);
                    checkValue("o_fetchReady", 0, fetchReady);
                    checkValue("o_instValid", 1, instValid);
                    checkValue("o_inst", heldInst, inst);
                end
                @(negedge clk);
                instReady = 1'b1;
            end
        join
        drain();
        endTest("back-pressure");

        // freeze the load before its first beat
        sendData(1'b0, 12'h044, `LEN_WORD, 32'h0);
        hold = 1'b1;
        fork
            sendFetch(12'h008);
            sendData(1'b0, 12'h048, `LEN_WORD, 32'h0);
            begin
                repeat (10) begin
                    @(posedge clk);
                    checkValue("o_dataReady", 0, dataReady);
                    checkValue("o_fetchReady", 0, fetchReady);
                    checkValue("o_dataRespValid", 0, dataRespValid);
                    checkValue("o_instValid", 0, instValid);
                end
                @(negedge clk);
                hold = 1'b0;
            end
        join
        drain();
        endTest("hold");

        for (n = 0; n < RANDOM_OPS; n++) begin
            opWord[n] = $random(seed);
            opData[n] = $random(seed);
        end
        @(posedge clk);
        randomReady = 1'b1;
        @(negedge clk);
        for (n = 0; n < RANDOM_OPS; n++) begin
            w = opWord[n];
            len = (w[3:2] == 2'd0) ? `LEN_BYTE : (w[3:2] == 2'd1) ? `LEN_HALF : `LEN_WORD;
            addr = '0;
            addr[6:0] = w[10:4];
            // w[1:0]: 0 fetch, 1 load, 2 and 3 store
            if (w[1:0] == 2'd0 || len == `LEN_WORD) begin
                addr[1:0] = 2'b00;
            end else if (len == `LEN_HALF) begin
                addr[0] = 1'b0;
            end
            if (w[1:0] == 2'd0) begin
                sendFetch(addr);
            end else begin
                sendData(w[1], addr, len, opData[n]);
            end
        end
        @(posedge clk);
        randomReady = 1'b0;
        @(negedge clk);
        instReady     = 1'b1;
        dataRespReady = 1'b1;
        drain();
        endTest("random mix");

        errCount += dut_i.protocolChecks.assertFails;
        $display("checks: %0d, mismatches: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/memSubsystem_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_assertions (
    input logic             clk,
    input logic             rst,
    input logic             i_fetchReady,
    input logic             i_dataReady,
    input logic             i_instValid,
    input memPkg::instT     i_inst,
    input logic             i_instReady,
    input logic             i_dataRespValid,
    input memPkg::dataRespT i_dataResp,
    input logic             i_dataRespReady,
    input logic             i_ramWe
);

    int assertFails = 0;

    // quiet outputs right after reset
    resetQuiet: assert property (@(posedge clk) $fell(rst) |->
        !i_fetchReady && !i_dataReady && !i_instValid && !i_dataRespValid && !i_ramWe)
        else begin
            assertFails++;
            $error("outputs active right after reset");
        end

    // ready is a one-cycle accept pulse
    acceptPulse: assert property (@(posedge clk) disable iff (rst)
        i_fetchReady || i_dataReady |=> !i_fetchReady && !i_dataReady)
        else begin
            assertFails++;
            $error("request ready held for more than one cycle");
        end

    instStable: assert property (@(posedge clk) disable iff (rst)
        i_instValid && !i_instReady |=> i_instValid && $stable(i_inst))
        else begin
            assertFails++;
            $error("instruction response changed while stalled");
        end

    dataRespStable: assert property (@(posedge clk) disable iff (rst)
        i_dataRespValid && !i_dataRespReady |=> i_dataRespValid && $stable(i_dataResp))
        else begin
            assertFails++;
            $error("data response changed while stalled");
        end

endmodule

`default_nettype wire

// ==== logic/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module memSubsystem (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_hold,
    input  logic             i_fetchValid,
    input  memPkg::fetchReqT i_fetchReq,
    output logic             o_fetchReady,
    input  logic             i_dataValid,
    input  memPkg::dataReqT  i_dataReq,
    output logic             o_dataReady,
    output logic             o_instValid,
    output memPkg::instT     o_inst,
    input  logic             i_instReady,
    output logic             o_dataRespValid,
    output memPkg::dataRespT o_dataResp,
    input  logic             i_dataRespReady
);
    import memPkg::*;

    memOpT                  op;
    memOpT                  doneOp;
    logic                   opStart;
    logic                   opBusy;
    logic                   opDone;
    logic [31:0]            word;
    logic                   instPush;
    instT                   routedInst;
    logic                   dataPush;
    dataRespT               routedResp;
    logic                   instFull;
    logic                   dataFull;
    logic [`MEM_ADDR_W-1:0] ramAddr;
    logic                   ramWe;
    logic [7:0]             ramWrByte;
    logic [7:0]             ramRdByte;

    memRequestDecode requestDecode (
        .clk          (clk),
        .rst          (rst),
        .i_hold       (i_hold),
        .i_fetchValid (i_fetchValid),
        .i_fetchReq   (i_fetchReq),
        .i_dataValid  (i_dataValid),
        .i_dataReq    (i_dataReq),
        .i_opBusy     (opBusy),
        .i_instFull   (instFull),
        .i_dataFull   (dataFull),
        .o_fetchReady (o_fetchReady),
        .o_dataReady  (o_dataReady),
        .o_opStart    (opStart),
        .o_op         (op)
    );

    memByteSequencer byteSequencer (
        .clk         (clk),
        .rst         (rst),
        .i_hold      (i_hold),
        .i_opStart   (opStart),
        .i_op        (op),
        .i_ramRdByte (ramRdByte),
        .o_opBusy    (opBusy),
        .o_ramAddr   (ramAddr),
        .o_ramWe     (ramWe),
        .o_ramWrByte (ramWrByte),
        .o_opDone    (opDone),
        .o_word      (word),
        .o_doneOp    (doneOp)
    );

    memResultRouter resultRouter (
        .clk        (clk),
        .rst        (rst),
        .i_opDone   (opDone),
        .i_word     (word),
        .i_doneOp   (doneOp),
        .o_instPush (instPush),
        .o_inst     (routedInst),
        .o_dataPush (dataPush),
        .o_dataResp (routedResp)
    );

    respSlot #(.payloadT(instT)) instSlot (
        .clk       (clk),
        .rst       (rst),
        .i_push    (instPush),
        .i_payload (routedInst),
        .o_valid   (o_instValid),
        .o_payload (o_inst),
        .i_ready   (i_instReady),
        .o_full    (instFull)
    );

    respSlot #(.payloadT(dataRespT)) dataSlot (
        .clk       (clk),
        .rst       (rst),
        .i_push    (dataPush),
        .i_payload (routedResp),
        .o_valid   (o_dataRespValid),
        .o_payload (o_dataResp),
        .i_ready   (i_dataRespReady),
        .o_full    (dataFull)
    );

    byteRam ram (
        .clk      (clk),
        .i_addr   (ramAddr),
        .i_we     (ramWe),
        .i_wrByte (ramWrByte),
        .o_rdByte (ramRdByte)
    );

endmodule

`default_nettype wire

// ==== memctrl/memResultRouter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module memResultRouter (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_opDone,
    input  logic [31:0]      i_word,
    input  memPkg::memOpT    i_doneOp,
    output logic             o_instPush,
    output memPkg::instT     o_inst,
    output logic             o_dataPush,
    output memPkg::dataRespT o_dataResp
);
    import memPkg::*;

    logic     isFetch;
    logic     isStore;
    dataRespT shapedResp;

    assign isFetch = (i_doneOp.kind == opFetch);
    assign isStore = (i_doneOp.kind == opStore);

    // zero-extend loads, stores only acknowledge
    always_comb begin
        shapedResp.storeAck = isStore;
        if (isStore) begin
            shapedResp.rdData = '0;
        end else begin
            case (i_doneOp.len)
                `LEN_BYTE: shapedResp.rdData = {24'd0, i_word[7:0]};
                `LEN_HALF: shapedResp.rdData = {16'd0, i_word[15:0]};
                `LEN_WORD: shapedResp.rdData = i_word;
                default:   shapedResp.rdData = i_word;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_instPush <= 1'b0;
            o_dataPush <= 1'b0;
        end else begin
            o_instPush <= i_opDone && isFetch;
            o_dataPush <= i_opDone && !isFetch;
        end
    end

    always_ff @(posedge clk) begin
        if (i_opDone) begin
            o_inst     <= i_word;
            o_dataResp <= shapedResp;
        end
    end

endmodule

`default_nettype wire

// ==== memctrl/memByteSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module memByteSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_hold,
    input  logic                   i_opStart,
    input  memPkg::memOpT          i_op,
    input  logic [7:0]             i_ramRdByte,
    output logic                   o_opBusy,
    output logic [`MEM_ADDR_W-1:0] o_ramAddr,
    output logic                   o_ramWe,
    output logic [7:0]             o_ramWrByte,
    output logic                   o_opDone,
    output logic [31:0]            o_word,
    output memPkg::memOpT          o_doneOp
);
    import memPkg::*;

    logic              active;
    logic              running;
    logic              step;
    logic              isStore;
    logic [`LEN_W-1:0] beat;
    logic [`LEN_W-1:0] cap;
    logic [`LEN_W-1:0] addrIdx;
    logic              capture;
    logic              lastWrite;
    logic              lastCap;
    logic              finish;
    logic [31:0]       asmWord;

    assign running = i_opStart || active;
    assign step    = running && !i_hold;
    assign isStore = (i_op.kind == opStore);

    // stays busy through opDone so a result never lands on a slot decode saw as free
    assign o_opBusy = running || o_opDone;

    // while held, keep reading the byte still owed to the capture side
    assign addrIdx     = i_hold ? cap : beat;
    assign o_ramAddr   = i_op.addr + {{(`MEM_ADDR_W - `LEN_W){1'b0}}, addrIdx};
    assign o_ramWrByte = i_op.wrData[{beat[1:0], 3'b000} +: 8];
    assign o_ramWe     = step && isStore && (beat < i_op.len);

    // read data trails its address by one cycle
    assign capture   = !isStore && (cap < beat);
    assign lastWrite = isStore && (beat == i_op.len - 1'b1);
    assign lastCap   = capture && (cap + 1'b1 == i_op.len);
    assign finish    = lastWrite || lastCap;

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            beat     <= '0;
            cap      <= '0;
            o_opDone <= 1'b0;
        end else begin
            // single-cycle pulse, even under hold
            o_opDone <= 1'b0;
            if (step) begin
                if (finish) begin
                    active   <= 1'b0;
                    beat     <= '0;
                    cap      <= '0;
                    o_opDone <= 1'b1;
                end else begin
                    active <= 1'b1;
                    if (beat < i_op.len) begin
                        beat <= beat + 1'b1;
                    end
                    if (capture) begin
                        cap <= cap + 1'b1;
                    end
                end
            end
        end
    end

    // little-endian lane fill
    always_ff @(posedge clk) begin
        if (step && capture) begin
            asmWord[{cap[1:0], 3'b000} +: 8] <= i_ramRdByte;
        end
        if (step && finish) begin
            o_doneOp <= i_op;
        end
    end

    assign o_word = asmWord;

endmodule

`default_nettype wire

// ==== memctrl/memRequestDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module memRequestDecode (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_hold,
    input  logic             i_fetchValid,
    input  memPkg::fetchReqT i_fetchReq,
    input  logic             i_dataValid,
    input  memPkg::dataReqT  i_dataReq,
    input  logic             i_opBusy,
    input  logic             i_instFull,
    input  logic             i_dataFull,
    output logic             o_fetchReady,
    output logic             o_dataReady,
    output logic             o_opStart,
    output memPkg::memOpT    o_op
);
    import memPkg::*;

    logic  canAccept;
    memOpT nextOp;

    assign canAccept = !i_opBusy && !i_hold;

    // data port has priority, a full slot only blocks its own port
    assign o_dataReady  = canAccept && i_dataValid && !i_dataFull;
    assign o_fetchReady = canAccept && i_fetchValid && !i_instFull && !o_dataReady;

    always_comb begin
        nextOp = '0;
        if (o_dataReady) begin
            nextOp.kind   = i_dataReq.store ? opStore : opLoad;
            nextOp.addr   = i_dataReq.addr;
            nextOp.len    = i_dataReq.len;
            nextOp.wrData = i_dataReq.wrData;
        end else begin
            nextOp.kind = opFetch;
            nextOp.addr = i_fetchReq.addr;
            nextOp.len  = `FETCH_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_opStart <= 1'b0;
        end else if (!i_hold) begin
            o_opStart <= o_dataReady || o_fetchReady;
        end
    end

    // stays put until the next accept
    always_ff @(posedge clk) begin
        if (o_dataReady || o_fetchReady) begin
            o_op <= nextOp;
        end
    end

endmodule

`default_nettype wire

// ==== logic/byteRam.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module byteRam (
    input  logic                   clk,
    input  logic [`MEM_ADDR_W-1:0] i_addr,
    input  logic                   i_we,
    input  logic [7:0]             i_wrByte,
    output logic [7:0]             o_rdByte
);

    logic [7:0] mem [`MEM_DEPTH];

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wrByte;
        end
        o_rdByte <= mem[i_addr];
    end

endmodule

`default_nettype wire

// ==== logic/respSlot.sv ====
`timescale 1ns/1ps
`default_nettype none

module respSlot #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_push,
    input  payloadT i_payload,
    output logic    o_valid,
    output payloadT o_payload,
    input  logic    i_ready,
    output logic    o_full
);

    // an incoming push already counts as occupied
    assign o_full = o_valid || i_push;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else if (i_push) begin
            o_valid <= 1'b1;
        end else if (o_valid && i_ready) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            o_payload <= i_payload;
        end
    end

endmodule

`default_nettype wire

// ==== common/memPkg.sv ====
`default_nettype none

package memPkg;

    `include "mem_consts.svh"

    typedef enum logic [1:0] {
        opFetch,
        opLoad,
        opStore
    } opKindT;

    // data port request, little-endian write data
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic                   store;
        logic [`LEN_W-1:0]      len;
        logic [31:0]            wrData;
    } dataReqT;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } fetchReqT;

    // operation held by decode while the sequencer runs it
    typedef struct packed {
        opKindT                 kind;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]      len;
        logic [31:0]            wrData;
    } memOpT;

    typedef struct packed {
        logic [31:0] rdData;
        logic        storeAck;
    } dataRespT;

    typedef logic [31:0] instT;

endpackage

`default_nettype wire

// ==== common/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address into the shared RAM
`define MEM_ADDR_W 12
`define MEM_DEPTH 4096

// length codes carry the byte count directly
`define LEN_W 3
`define LEN_BYTE 3'd1
`define LEN_HALF 3'd2
`define LEN_WORD 3'd4

// a fetch always reads one full word
`define FETCH_BYTES 3'd4

`endif
